//--- exe_core.f
verilog/exe_core_pkg.sv
verilog/ex_stage_if.sv
verilog/mem_stage_if.sv
verilog/id_decode.sv
verilog/alu.sv
verilog/ex_stage.sv
verilog/wb_result.sv
verilog/exe_core.sv
dv/exe_core_assertions.sv
dv/exe_core_checker.sv
dv/exe_core_tb.sv

//--- Bender.yml
package:
  name: exe_core

sources:
  - verilog/exe_core_pkg.sv
  - verilog/ex_stage_if.sv
  - verilog/mem_stage_if.sv
  - verilog/id_decode.sv
  - verilog/alu.sv
  - verilog/ex_stage.sv
  - verilog/wb_result.sv
  - verilog/exe_core.sv
  - target: test
    files:
      - dv/exe_core_assertions.sv
      - dv/exe_core_checker.sv
      - dv/exe_core_tb.sv

//--- dv/exe_core_tb.sv
module exe_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import exe_core_pkg::*;

    localparam int RAM_AW     = 8;
    localparam int NUM_INSTS  = 600;
    localparam int MAX_CYCLES = NUM_INSTS * 40 + 100;

    logic        clk = 1'b0;
    logic        resetn, flush, inst_valid, inst_allowin;
    logic [31:0] inst, pc, rj_value, rkd_value;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr, data_sram_wdata, data_sram_rdata;
    logic        wb_valid, wb_rf_we, wb_excep;
    logic [31:0] wb_pc, wb_rf_wdata;
    logic [4:0]  wb_rf_waddr;
    ecode_e      wb_ecode;

    logic [31:0] ram [2**RAM_AW];
    logic [16:0] ops_3r [12] = '{OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU, OP_AND, OP_OR,
                                 OP_XOR, OP_NOR, OP_SLL_W, OP_SRL_W, OP_SRA_W, OP_MUL_W};
    logic [9:0]  ops_imm [6] = '{OP_ADDI_W, OP_SLTI, OP_SLTUI, OP_ANDI, OP_ORI, OP_XORI};
    logic [9:0]  ops_mem [8] = '{OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU,
                                 OP_ST_B, OP_ST_H, OP_ST_W};
    integer      seed = 8674;
    int          sent = 0;
    int          cycles = 0;
    logic        took = 1'b0;  // input transfer at the last edge

    exe_core i_dut (.*);

    exe_core_checker #(.RAM_AW(RAM_AW)) i_checker (.*);

    bind ex_stage exe_core_assertions i_assertions (
        .clk          (clk),
        .resetn       (resetn),
        .flush        (flush),
        .data_sram_en (data_sram_en),
        .allowin      (id.allowin)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] fill_word(int i);
        return {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0] + 8'h31, i[7:0]};
    endfunction

    // data RAM, one cycle read latency
    always @(posedge clk) begin
        if (data_sram_en) begin
            for (int i = 0; i < 4; i++) begin
                if (data_sram_we[i]) begin
                    ram[data_sram_addr[RAM_AW+1:2]][8*i +: 8] <= data_sram_wdata[8*i +: 8];
                end
            end
            data_sram_rdata <= ram[data_sram_addr[RAM_AW+1:2]];
        end
    end

    always @(posedge clk) begin
        took <= inst_valid && inst_allowin;
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run exceeded %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic next_inst;
        int          kind;
        logic [11:0] imm;
        kind      = {$random(seed)} % 100;
        pc        = pc + 4;
        rj_value  = $random(seed);
        rkd_value = $random(seed);
        if (kind < 3) begin
            inst = {10'h3ff, 22'($random(seed))};  // matches no opcode
        end else if (kind < 40) begin
            inst = {ops_3r[{$random(seed)} % 12], 15'($random(seed))};
        end else if (kind < 65) begin
            inst = {ops_imm[{$random(seed)} % 6], 22'($random(seed))};
        end else begin
            imm      = 12'({$random(seed)} % 32) - 12'd16;
            rj_value = {$random(seed)} % 1021;
            inst     = {ops_mem[{$random(seed)} % 8], imm, 10'($random(seed))};
        end
    endtask

    initial begin
        resetn          = 1'b0;
        flush           = 1'b0;
        inst_valid      = 1'b0;
        inst            = '0;
        pc              = 32'h1c00_0000;
        rj_value        = '0;
        rkd_value       = '0;
        data_sram_rdata = '0;
        for (int i = 0; i < 2**RAM_AW; i++) ram[i] = fill_word(i);
        repeat (10) @(negedge clk);
        resetn = 1'b1;
        while (sent < NUM_INSTS) begin
            @(negedge clk);
            if (took) sent++;
            flush = {$random(seed)} % 40 == 0;
            if (!inst_valid || took) begin  // hold while stalled
                inst_valid = sent < NUM_INSTS && {$random(seed)} % 4 != 0;
                if (inst_valid) next_inst();
            end
        end
        flush = 1'b0;
        while (i_checker.slot_valid || i_checker.exp_pending) begin
            @(negedge clk);  // last instruction still on its way
        end
        $display("errors: %0d", i_checker.error_count);
        if (i_checker.error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end
endmodule

//--- dv/exe_core_checker.sv
module exe_core_checker #(
    parameter int RAM_AW = 8
) (
    input logic                 clk,
    input logic                 resetn,
    input logic                 flush,
    input logic                 inst_valid,
    input logic                 inst_allowin,
    input logic [31:0]          inst,
    input logic [31:0]          pc,
    input logic [31:0]          rj_value,
    input logic [31:0]          rkd_value,
    input logic                 data_sram_en,
    input logic [3:0]           data_sram_we,
    input logic [31:0]          data_sram_addr,
    input logic [31:0]          data_sram_wdata,
    input logic                 wb_valid,
    input logic [31:0]          wb_pc,
    input logic                 wb_rf_we,
    input logic [4:0]           wb_rf_waddr,
    input logic [31:0]          wb_rf_wdata,
    input logic                 wb_excep,
    input exe_core_pkg::ecode_e wb_ecode
);
    timeunit 1ns;
    timeprecision 100ps;
    import exe_core_pkg::*;

    int          error_count = 0;
    logic [31:0] shadow [2**RAM_AW];
    logic        slot_valid;       // instruction held in execute
    logic [31:0] slot_inst, slot_pc, slot_rj, slot_rkd;
    int          slot_age;
    logic        exp_pending, exp_we;
    logic [31:0] exp_pc, exp_wdata;
    logic [4:0]  exp_waddr;
    ecode_e      exp_ecode;
    logic        m_load, m_store, m_unsigned, m_we;
    mem_size_e   m_size;
    logic [31:0] m_alu, m_data, m_wdata;
    logic [3:0]  m_be;
    ecode_e      m_ecode;
    int          m_latency;

    function automatic logic [31:0] fill_word(int i);
        return {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0] + 8'h31, i[7:0]};
    endfunction

    initial begin
        for (int i = 0; i < 2**RAM_AW; i++) shadow[i] = fill_word(i);
    end

    task automatic mismatch(string name, logic [31:0] got, logic [31:0] exp);
        error_count++;
        $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic model_slot;
        logic [31:0] simm, uimm, word;
        logic [4:0]  sh;
        logic [7:0]  b;
        logic [15:0] h;
        simm = {{20{slot_inst[21]}}, slot_inst[21:10]};
        uimm = {20'b0, slot_inst[21:10]};
        sh   = slot_rkd[4:0];
        {m_load, m_store, m_unsigned} = 3'b000;
        m_size    = MEM_WORD;
        m_ecode   = ECODE_NONE;
        m_latency = 1;
        case (slot_inst[31:15])
            OP_ADD_W: m_alu = slot_rj + slot_rkd;
            OP_SUB_W: m_alu = slot_rj - slot_rkd;
            OP_SLT:   m_alu = {31'b0, $signed(slot_rj) < $signed(slot_rkd)};
            OP_SLTU:  m_alu = {31'b0, slot_rj < slot_rkd};
            OP_AND:   m_alu = slot_rj & slot_rkd;
            OP_OR:    m_alu = slot_rj | slot_rkd;
            OP_XOR:   m_alu = slot_rj ^ slot_rkd;
            OP_NOR:   m_alu = ~(slot_rj | slot_rkd);
            OP_SLL_W: m_alu = slot_rj << sh;
            OP_SRL_W: m_alu = slot_rj >> sh;
            OP_SRA_W: m_alu = $signed(slot_rj) >>> sh;
            OP_MUL_W: begin
                m_alu = slot_rj * slot_rkd;
                for (int i = 0; i < 32; i++) begin
                    if (slot_rkd[i]) m_latency = i + 3;  // start cycle plus one per bit
                end
                if (slot_rkd == 0) m_latency = 2;
            end
            default: begin
                m_alu = slot_rj + simm;  // also the memory address
                case (slot_inst[31:22])
                    OP_ADDI_W: ;
                    OP_SLTI:   m_alu = {31'b0, $signed(slot_rj) < $signed(simm)};
                    OP_SLTUI:  m_alu = {31'b0, slot_rj < simm};
                    OP_ANDI:   m_alu = slot_rj & uimm;
                    OP_ORI:    m_alu = slot_rj | uimm;
                    OP_XORI:   m_alu = slot_rj ^ uimm;
                    OP_LD_B, OP_LD_BU: begin
                        m_load     = 1'b1;
                        m_unsigned = slot_inst[31:22] == OP_LD_BU;
                        m_size     = MEM_BYTE;
                    end
                    OP_LD_H, OP_LD_HU: begin
                        m_load     = 1'b1;
                        m_unsigned = slot_inst[31:22] == OP_LD_HU;
                        m_size     = MEM_HALF;
                    end
                    OP_LD_W:   m_load = 1'b1;
                    OP_ST_B, OP_ST_H, OP_ST_W: begin
                        m_store = 1'b1;
                        if (slot_inst[31:22] == OP_ST_B) m_size = MEM_BYTE;
                        if (slot_inst[31:22] == OP_ST_H) m_size = MEM_HALF;
                    end
                    default:   m_ecode = ECODE_INE;
                endcase
            end
        endcase
        if (m_ecode == ECODE_NONE && (m_load || m_store) &&
            ((m_size == MEM_HALF && m_alu[0]) || (m_size == MEM_WORD && m_alu[1:0] != 2'b00)))
            m_ecode = ECODE_ALE;
        m_we = !m_store && m_ecode == ECODE_NONE;
        case (m_size)
            MEM_BYTE: {m_be, m_wdata} = {4'b0001 << m_alu[1:0], {4{slot_rkd[7:0]}}};
            MEM_HALF: {m_be, m_wdata} = {m_alu[1] ? 4'b1100 : 4'b0011, {2{slot_rkd[15:0]}}};
            default:  {m_be, m_wdata} = {4'b1111, slot_rkd};
        endcase
        word = shadow[m_alu[RAM_AW+1:2]];
        b    = word[m_alu[1:0]*8 +: 8];
        h    = m_alu[1] ? word[31:16] : word[15:0];
        case (m_size)
            MEM_BYTE: m_data = {{24{b[7] && !m_unsigned}}, b};
            MEM_HALF: m_data = {{16{h[15] && !m_unsigned}}, h};
            default:  m_data = word;
        endcase
        if (!m_load) m_data = m_alu;
    endtask

    always @(posedge clk) begin
        logic       leaving, mem_ok, exp_allowin;
        logic [3:0] exp_be;
        if (!resetn) begin
            slot_valid  = 1'b0;
            exp_pending = 1'b0;
        end else begin
            if (wb_valid && !exp_pending) begin
                error_count++;
                $display("error at %0t: writeback appeared with no instruction due", $time);
            end else if (!wb_valid && exp_pending) begin
                error_count++;
                $display("error at %0t: instruction at pc %h never wrote back", $time, exp_pc);
            end else if (wb_valid) begin
                if (wb_pc !== exp_pc) mismatch("wb_pc", wb_pc, exp_pc);
                if (wb_rf_we !== exp_we) mismatch("wb_rf_we", wb_rf_we, exp_we);
                if (exp_we && wb_rf_waddr !== exp_waddr) begin
                    mismatch("wb_rf_waddr", wb_rf_waddr, exp_waddr);
                end
                if (exp_we && wb_rf_wdata !== exp_wdata) begin
                    mismatch("wb_rf_wdata", wb_rf_wdata, exp_wdata);
                end
                if (wb_excep !== (exp_ecode != ECODE_NONE)) begin
                    mismatch("wb_excep", wb_excep, exp_ecode != ECODE_NONE);
                end
                if (wb_ecode !== exp_ecode) mismatch("wb_ecode", wb_ecode, exp_ecode);
            end
            exp_pending = 1'b0;

            leaving     = slot_valid && inst_allowin;  // result stage always accepts
            mem_ok      = 1'b0;
            exp_allowin = 1'b1;  // execute empty
            if (slot_valid) begin
                slot_age++;
                model_slot();
                exp_allowin = slot_age >= m_latency;
                mem_ok      = leaving && (m_load || m_store) && m_ecode == ECODE_NONE && !flush;
            end
            if (inst_allowin !== exp_allowin) mismatch("inst_allowin", inst_allowin, exp_allowin);
            if (data_sram_en !== mem_ok) begin
                mismatch("data_sram_en", data_sram_en, mem_ok);
            end else if (mem_ok) begin
                exp_be = m_store ? m_be : 4'b0000;
                if (data_sram_addr !== m_alu) mismatch("data_sram_addr", data_sram_addr, m_alu);
                if (data_sram_we !== exp_be) mismatch("data_sram_we", data_sram_we, exp_be);
                if (m_store && data_sram_wdata !== m_wdata) begin
                    mismatch("data_sram_wdata", data_sram_wdata, m_wdata);
                end
                for (int i = 0; i < 4; i++) begin
                    if (m_store && m_be[i]) begin
                        shadow[m_alu[RAM_AW+1:2]][8*i +: 8] = m_wdata[8*i +: 8];
                    end
                end
            end

            if (leaving && !flush) begin  // flushed in execute, never written back
                exp_pending = 1'b1;
                exp_pc      = slot_pc;
                exp_we      = m_we;
                exp_waddr   = slot_inst[4:0];
                exp_wdata   = m_data;
                exp_ecode   = m_ecode;
            end
            if (leaving || flush) slot_valid = 1'b0;
            if (inst_valid && inst_allowin && !flush) begin
                {slot_inst, slot_pc, slot_rj, slot_rkd} = {inst, pc, rj_value, rkd_value};
                slot_age   = 0;
                slot_valid = 1'b1;
            end
        end
    end
endmodule

//--- dv/exe_core_assertions.sv
module exe_core_assertions (
    input logic clk,
    input logic resetn,
    input logic flush,
    input logic data_sram_en,
    input logic allowin
);
    timeunit 1ns;
    timeprecision 100ps;

    // an access leaves execute in its request cycle, so it is made once
    en_only_when_leaving: assert property (@(posedge clk) disable iff (!resetn)
        data_sram_en |-> allowin)
        else $error("data_sram_en is high while execute is stalled");

    no_en_after_flush: assert property (@(posedge clk) disable iff (!resetn)
        flush |=> !data_sram_en)
        else $error("data_sram_en is high in the cycle after a flush");

    // execute is empty once reset has been seen
    allowin_after_reset: assert property (@(posedge clk)
        !resetn |=> allowin)
        else $error("inst_allowin is low after reset");
endmodule

//--- verilog/exe_core.sv
module exe_core (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 flush,
    input  logic                 inst_valid,
    output logic                 inst_allowin,
    input  logic [31:0]          inst,
    input  logic [31:0]          pc,
    input  logic [31:0]          rj_value,
    input  logic [31:0]          rkd_value,
    output logic                 data_sram_en,
    output logic [3:0]           data_sram_we,
    output logic [31:0]          data_sram_addr,
    output logic [31:0]          data_sram_wdata,
    input  logic [31:0]          data_sram_rdata,
    output logic                 wb_valid,
    output logic [31:0]          wb_pc,
    output logic                 wb_rf_we,
    output logic [4:0]           wb_rf_waddr,
    output logic [31:0]          wb_rf_wdata,
    output logic                 wb_excep,
    output exe_core_pkg::ecode_e wb_ecode
);
    ex_stage_if  ex_if ();
    mem_stage_if ms_if ();

    id_decode i_id_decode (
        .inst_valid   (inst_valid),
        .inst_allowin (inst_allowin),
        .inst         (inst),
        .pc           (pc),
        .rj_value     (rj_value),
        .rkd_value    (rkd_value),
        .ex           (ex_if)
    );

    ex_stage i_ex_stage (
        .clk             (clk),
        .resetn          (resetn),
        .flush           (flush),
        .id              (ex_if),
        .ms              (ms_if),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    wb_result i_wb_result (
        .clk             (clk),
        .resetn          (resetn),
        .ms              (ms_if),
        .data_sram_rdata (data_sram_rdata),
        .wb_valid        (wb_valid),
        .wb_pc           (wb_pc),
        .wb_rf_we        (wb_rf_we),
        .wb_rf_waddr     (wb_rf_waddr),
        .wb_rf_wdata     (wb_rf_wdata),
        .wb_excep        (wb_excep),
        .wb_ecode        (wb_ecode)
    );
endmodule

//--- verilog/wb_result.sv
module wb_result (
    input  logic                            clk,
    input  logic                            resetn,
    mem_stage_if.receiver                   ms,
    input  logic [exe_core_pkg::DATA_W-1:0] data_sram_rdata,
    output logic                            wb_valid,
    output logic [exe_core_pkg::DATA_W-1:0] wb_pc,
    output logic                            wb_rf_we,
    output logic [4:0]                      wb_rf_waddr,
    output logic [exe_core_pkg::DATA_W-1:0] wb_rf_wdata,
    output logic                            wb_excep,
    output exe_core_pkg::ecode_e            wb_ecode
);
    import exe_core_pkg::*;

    logic              rs_rf_we;
    logic [DATA_W-1:0] rs_alu_result;
    logic              rs_load;
    mem_size_e         rs_size;
    logic              rs_unsigned;
    logic [1:0]        rs_addr_low;
    logic [7:0]        load_byte;
    logic [15:0]       load_half;
    logic [DATA_W-1:0] load_data;

    assign ms.allowin = 1'b1;  // result stage never stalls

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ms.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms.valid && ms.allowin) begin
            wb_pc         <= ms.pc;
            rs_rf_we      <= ms.rf_we;
            wb_rf_waddr   <= ms.rf_waddr;
            rs_alu_result <= ms.alu_result;
            rs_load       <= ms.mem_load;
            rs_size       <= ms.mem_size;
            rs_unsigned   <= ms.mem_unsigned;
            rs_addr_low   <= ms.addr_low;
            wb_ecode      <= ms.ecode;
        end
    end

    // rdata arrives the cycle after the request, i.e. now
    assign load_byte = data_sram_rdata[rs_addr_low*8 +: 8];
    assign load_half = rs_addr_low[1] ? data_sram_rdata[31:16] : data_sram_rdata[15:0];

    always_comb begin
        case (rs_size)
            MEM_BYTE: load_data = {{24{load_byte[7] && !rs_unsigned}}, load_byte};
            MEM_HALF: load_data = {{16{load_half[15] && !rs_unsigned}}, load_half};
            default:  load_data = data_sram_rdata;
        endcase
    end

    assign wb_rf_wdata = rs_load ? load_data : rs_alu_result;
    assign wb_rf_we    = wb_valid && rs_rf_we;
    assign wb_excep    = wb_valid && wb_ecode != ECODE_NONE;
endmodule

//--- verilog/ex_stage.sv
module ex_stage (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            flush,
    ex_stage_if.receiver                    id,
    mem_stage_if.sender                     ms,
    output logic                            data_sram_en,
    output logic [3:0]                      data_sram_we,
    output logic [exe_core_pkg::DATA_W-1:0] data_sram_addr,
    output logic [exe_core_pkg::DATA_W-1:0] data_sram_wdata
);
    import exe_core_pkg::*;

    logic              ex_valid;
    logic              ex_start;    // first cycle in execute
    logic [DATA_W-1:0] ex_pc;
    alu_op_e           ex_alu_op;
    logic [DATA_W-1:0] ex_src1;
    logic [DATA_W-1:0] ex_src2;
    logic [DATA_W-1:0] ex_rkd_value;
    logic              ex_rf_we;
    logic [4:0]        ex_rf_waddr;
    logic              ex_load;
    logic              ex_store;
    mem_size_e         ex_size;
    logic              ex_unsigned;
    ecode_e            ex_ecode_in;

    logic              transfer;
    logic              alu_complete;
    logic [DATA_W-1:0] alu_result;
    logic              ale;
    ecode_e            ex_ecode;
    logic [3:0]        byte_en;

    assign transfer   = id.valid && id.allowin;
    assign id.allowin = !ex_valid || (alu_complete && ms.allowin);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
            ex_start <= 1'b0;
        end else begin
            ex_start <= transfer && !flush;
            if (flush) begin
                ex_valid <= 1'b0;  // input transfer dropped too
            end else if (id.allowin) begin
                ex_valid <= id.valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (transfer) begin
            ex_pc        <= id.pc;
            ex_alu_op    <= id.alu_op;
            ex_src1      <= id.src1;
            ex_src2      <= id.src2;
            ex_rkd_value <= id.rkd_value;
            ex_rf_we     <= id.rf_we;
            ex_rf_waddr  <= id.rf_waddr;
            ex_load      <= id.mem_load;
            ex_store     <= id.mem_store;
            ex_size      <= id.mem_size;
            ex_unsigned  <= id.mem_unsigned;
            ex_ecode_in  <= id.ecode;
        end
    end

    alu i_alu (
        .clk      (clk),
        .resetn   (resetn),
        .start    (ex_start),
        .alu_op   (ex_alu_op),
        .src1     (ex_src1),
        .src2     (ex_src2),
        .result   (alu_result),
        .complete (alu_complete)
    );

    assign ale = (ex_load || ex_store) &&
                 ((ex_size == MEM_HALF && alu_result[0]) ||
                  (ex_size == MEM_WORD && alu_result[1:0] != 2'b00));
    assign ex_ecode = ex_ecode_in != ECODE_NONE ? ex_ecode_in :
                      ale ? ECODE_ALE : ECODE_NONE;

    always_comb begin
        case (ex_size)
            MEM_BYTE: begin
                byte_en         = 4'b0001 << alu_result[1:0];
                data_sram_wdata = {4{ex_rkd_value[7:0]}};
            end
            MEM_HALF: begin
                byte_en         = alu_result[1] ? 4'b1100 : 4'b0011;
                data_sram_wdata = {2{ex_rkd_value[15:0]}};
            end
            default: begin
                byte_en         = 4'b1111;
                data_sram_wdata = ex_rkd_value;
            end
        endcase
    end

    assign data_sram_en   = ex_valid && (ex_load || ex_store) && ex_ecode == ECODE_NONE && !flush;
    assign data_sram_we   = {4{data_sram_en && ex_store}} & byte_en;
    assign data_sram_addr = alu_result;

    assign ms.valid        = ex_valid && alu_complete && !flush;  // flushed one is dropped
    assign ms.pc           = ex_pc;
    assign ms.alu_result   = alu_result;
    assign ms.rf_we        = ex_rf_we && ex_ecode == ECODE_NONE;
    assign ms.rf_waddr     = ex_rf_waddr;
    assign ms.mem_load     = ex_load;
    assign ms.mem_size     = ex_size;
    assign ms.mem_unsigned = ex_unsigned;
    assign ms.addr_low     = alu_result[1:0];
    assign ms.ecode        = ex_ecode;
endmodule

//--- verilog/alu.sv
module alu (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            start,
    input  exe_core_pkg::alu_op_e           alu_op,
    input  logic [exe_core_pkg::DATA_W-1:0] src1,
    input  logic [exe_core_pkg::DATA_W-1:0] src2,
    output logic [exe_core_pkg::DATA_W-1:0] result,
    output logic                            complete
);
    import exe_core_pkg::*;

    logic [4:0]        shamt;
    logic              mul_load;
    logic [DATA_W-1:0] mcand;   // shifted multiplicand
    logic [DATA_W-1:0] mplier;  // remaining multiplier bits
    logic [DATA_W-1:0] acc;

    assign shamt    = src2[4:0];
    assign mul_load = start && alu_op == ALU_MUL;

    // the multiplier register is the only state, zero means idle or done
    always_ff @(posedge clk) begin
        if (!resetn) begin
            mplier <= '0;
        end else if (mul_load) begin
            mplier <= src2;
        end else if (mplier != '0) begin
            mplier <= mplier >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_load) begin
            acc   <= '0;
            mcand <= src1;
        end else if (mplier != '0) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand <= mcand << 1;  // upper product bits drop off
        end
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_SLT:  result = {{(DATA_W-1){1'b0}}, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {{(DATA_W-1){1'b0}}, src1 < src2};
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(src1) >>> shamt);
            ALU_MUL:  result = acc;
            default:  result = '0;
        endcase
    end

    // first cycle of a multiply is never complete
    assign complete = (alu_op != ALU_MUL) || (!start && mplier == '0);
endmodule

//--- verilog/id_decode.sv
module id_decode (
    input  logic                             inst_valid,
    output logic                             inst_allowin,
    input  exe_core_pkg::inst_u              inst,
    input  logic [exe_core_pkg::DATA_W-1:0]  pc,
    input  logic [exe_core_pkg::DATA_W-1:0]  rj_value,
    input  logic [exe_core_pkg::DATA_W-1:0]  rkd_value,
    ex_stage_if.sender                       ex
);
    import exe_core_pkg::*;

    logic              is_3r;
    logic [DATA_W-1:0] simm;
    logic [DATA_W-1:0] uimm;

    assign simm = {{(DATA_W-12){inst.ri12.imm[11]}}, inst.ri12.imm};
    assign uimm = {{(DATA_W-12){1'b0}}, inst.ri12.imm}; // logic immediates

    assign inst_allowin = ex.allowin;
    assign ex.valid     = inst_valid;
    assign ex.pc        = pc;
    assign ex.src1      = rj_value;
    assign ex.rkd_value = rkd_value;
    assign ex.rf_waddr  = inst.r3.rd;  // rd sits at the same place in both views

    always_comb begin
        is_3r           = 1'b1;
        ex.alu_op       = ALU_ADD;
        ex.src2         = rkd_value;
        ex.rf_we        = 1'b1;
        ex.mem_load     = 1'b0;
        ex.mem_store    = 1'b0;
        ex.mem_size     = MEM_WORD;
        ex.mem_unsigned = 1'b0;
        ex.ecode        = ECODE_NONE;

        case (inst.r3.opcode)
            OP_ADD_W: ex.alu_op = ALU_ADD;
            OP_SUB_W: ex.alu_op = ALU_SUB;
            OP_SLT:   ex.alu_op = ALU_SLT;
            OP_SLTU:  ex.alu_op = ALU_SLTU;
            OP_AND:   ex.alu_op = ALU_AND;
            OP_OR:    ex.alu_op = ALU_OR;
            OP_XOR:   ex.alu_op = ALU_XOR;
            OP_NOR:   ex.alu_op = ALU_NOR;
            OP_SLL_W: ex.alu_op = ALU_SLL;
            OP_SRL_W: ex.alu_op = ALU_SRL;
            OP_SRA_W: ex.alu_op = ALU_SRA;
            OP_MUL_W: ex.alu_op = ALU_MUL;
            default:  is_3r = 1'b0;
        endcase

        if (!is_3r) begin
            ex.src2 = simm;  // address for loads and stores as well
            case (inst.ri12.opcode)
                OP_ADDI_W: ex.alu_op = ALU_ADD;
                OP_SLTI:   ex.alu_op = ALU_SLT;
                OP_SLTUI:  ex.alu_op = ALU_SLTU;
                OP_ANDI: begin
                    ex.alu_op = ALU_AND;
                    ex.src2   = uimm;
                end
                OP_ORI: begin
                    ex.alu_op = ALU_OR;
                    ex.src2   = uimm;
                end
                OP_XORI: begin
                    ex.alu_op = ALU_XOR;
                    ex.src2   = uimm;
                end
                OP_LD_B, OP_LD_BU: begin
                    ex.mem_load     = 1'b1;
                    ex.mem_size     = MEM_BYTE;
                    ex.mem_unsigned = inst.ri12.opcode == OP_LD_BU;
                end
                OP_LD_H, OP_LD_HU: begin
                    ex.mem_load     = 1'b1;
                    ex.mem_size     = MEM_HALF;
                    ex.mem_unsigned = inst.ri12.opcode == OP_LD_HU;
                end
                OP_LD_W: ex.mem_load = 1'b1;
                OP_ST_B, OP_ST_H, OP_ST_W: begin
                    ex.mem_store = 1'b1;
                    ex.rf_we     = 1'b0;
                    ex.mem_size  = inst.ri12.opcode == OP_ST_B ? MEM_BYTE :
                                   inst.ri12.opcode == OP_ST_H ? MEM_HALF : MEM_WORD;
                end
                default: begin
                    ex.ecode = ECODE_INE;
                    ex.rf_we = 1'b0;
                end
            endcase
        end
    end
endmodule

//--- verilog/mem_stage_if.sv
interface mem_stage_if;
    import exe_core_pkg::*;

    logic              valid;
    logic              allowin;
    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] alu_result;
    logic              rf_we;
    logic [4:0]        rf_waddr;
    logic              mem_load;
    mem_size_e         mem_size;
    logic              mem_unsigned;
    logic [1:0]        addr_low;    // byte lane of the load
    ecode_e            ecode;

    modport sender (
        output valid, pc, alu_result, rf_we, rf_waddr, mem_load, mem_size,
               mem_unsigned, addr_low, ecode,
        input  allowin
    );

    modport receiver (
        input  valid, pc, alu_result, rf_we, rf_waddr, mem_load, mem_size,
               mem_unsigned, addr_low, ecode,
        output allowin
    );
endinterface

//--- verilog/ex_stage_if.sv
interface ex_stage_if;
    import exe_core_pkg::*;

    logic              valid;
    logic              allowin;
    logic [DATA_W-1:0] pc;
    alu_op_e           alu_op;
    logic [DATA_W-1:0] src1;
    logic [DATA_W-1:0] src2;
    logic [DATA_W-1:0] rkd_value;    // store data
    logic              rf_we;
    logic [4:0]        rf_waddr;
    logic              mem_load;
    logic              mem_store;
    mem_size_e         mem_size;
    logic              mem_unsigned;
    ecode_e            ecode;

    modport sender (
        output valid, pc, alu_op, src1, src2, rkd_value, rf_we, rf_waddr,
               mem_load, mem_store, mem_size, mem_unsigned, ecode,
        input  allowin
    );

    modport receiver (
        input  valid, pc, alu_op, src1, src2, rkd_value, rf_we, rf_waddr,
               mem_load, mem_store, mem_size, mem_unsigned, ecode,
        output allowin
    );
endinterface

//--- verilog/exe_core_pkg.sv
package exe_core_pkg;

    localparam int DATA_W = 32;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_MUL  = 4'd11
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        ECODE_NONE = 2'd0,
        ECODE_ALE  = 2'd1, // misaligned half or word access
        ECODE_INE  = 2'd2  // unknown encoding
    } ecode_e;

    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_3r_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_2ri12_t;

    typedef union packed {
        inst_3r_t    r3;
        inst_2ri12_t ri12;
    } inst_u;

    // 3R opcodes, inst[31:15]
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_SLTU  = 17'h00025;
    localparam logic [16:0] OP_NOR   = 17'h00028;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;
    localparam logic [16:0] OP_SLL_W = 17'h0002e;
    localparam logic [16:0] OP_SRL_W = 17'h0002f;
    localparam logic [16:0] OP_SRA_W = 17'h00030;
    localparam logic [16:0] OP_MUL_W = 17'h00038;

    // 2RI12 opcodes, inst[31:22]
    localparam logic [9:0] OP_SLTI   = 10'h008;
    localparam logic [9:0] OP_SLTUI  = 10'h009;
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_ANDI   = 10'h00d;
    localparam logic [9:0] OP_ORI    = 10'h00e;
    localparam logic [9:0] OP_XORI   = 10'h00f;
    localparam logic [9:0] OP_LD_B   = 10'h0a0;
    localparam logic [9:0] OP_LD_H   = 10'h0a1;
    localparam logic [9:0] OP_LD_W   = 10'h0a2;
    localparam logic [9:0] OP_ST_B   = 10'h0a4;
    localparam logic [9:0] OP_ST_H   = 10'h0a5;
    localparam logic [9:0] OP_ST_W   = 10'h0a6;
    localparam logic [9:0] OP_LD_BU  = 10'h0a8;
    localparam logic [9:0] OP_LD_HU  = 10'h0a9;

endpackage
